// ==== ip_tx_defines.svh ====
// IPv4 transmitter constants
// field widths and the fixed values of the IPv4 header
// this transmitter sends no options, so header length stays at 5 words

`ifndef IP_TX_DEFINES_SVH
`define IP_TX_DEFINES_SVH

// fixed header fields
`define IP_VERSION 4'd4
`define IP_IHL 4'd5

// header size in bytes for IHL = 5
`define IP_HDR_BYTES 20

// field widths
`define MAC_W 48
`define IP_W 32
`define LEN_W 16

// header byte index, 0 to 19
`define HDR_IDX_W 5

`endif

// ==== ip_tx_pkg.sv ====
// IPv4 transmitter types
// header field vectors, the Ethernet and IP header structs,
// the byte stream beat and the framer state encoding

`default_nettype none

`include "ip_tx_defines.svh"

package ip_tx_pkg;

    typedef logic [`MAC_W-1:0] mac_addr_t;
    typedef logic [`IP_W-1:0] ip_addr_t;
    typedef logic [`LEN_W-1:0] ip_len_t;
    typedef logic [`LEN_W-1:0] csum_t;
    typedef logic [`HDR_IDX_W-1:0] hdr_idx_t;
    typedef logic [7:0] byte_t;

    // fields passed through to the Ethernet MAC
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // IPv4 fields supplied by the user, version and IHL are fixed
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_len_t     length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        byte_t       ttl;
        byte_t       protocol;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    // one byte of the payload stream
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_HEADER,
        WRITE_PAYLOAD,
        WRITE_PAYLOAD_LAST
    } framer_state_t;

endpackage

`default_nettype wire

// ==== ip_hdr_checksum.sv ====
// IPv4 header checksum
// accumulates the ones' complement sum of the header words while the
// framer walks through the header, one word per advance step
// result is ready by the time the checksum bytes go out

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module ip_hdr_checksum (
    input  logic                clk,
    input  ip_tx_pkg::ip_hdr_t  hdr,
    input  ip_tx_pkg::hdr_idx_t idx,
    input  logic                advance,
    output ip_tx_pkg::csum_t    csum
);
    import ip_tx_pkg::*;

    csum_t sum_reg;
    csum_t word;
    logic  add_en;

    // add with end-around carry
    function automatic csum_t add_1c(input csum_t a, input csum_t b);
        logic [`LEN_W:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[`LEN_W-1:0] + csum_t'(t[`LEN_W]);
    endfunction

    // word added at each step, checksum word itself counts as zero
    always_comb begin
        word = '0;
        add_en = 1'b1;
        case (idx)
            5'd2: word = hdr.length;
            5'd3: word = hdr.identification;
            5'd4: word = {hdr.flags, hdr.fragment_offset};
            5'd5: word = {hdr.ttl, hdr.protocol};
            5'd6: word = hdr.source_ip[31:16];
            5'd7: word = hdr.source_ip[15:0];
            5'd8: word = hdr.dest_ip[31:16];
            5'd9: word = hdr.dest_ip[15:0];
            default: add_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (idx == hdr_idx_t'(1)) begin
                // first word is version, IHL and the TOS byte
                sum_reg <= {`IP_VERSION, `IP_IHL, hdr.dscp, hdr.ecn};
            end else if (add_en) begin
                sum_reg <= add_1c(sum_reg, word);
            end
        end
    end

    assign csum = ~sum_reg;

endmodule

`default_nettype wire

// ==== ip_tx_framer.sv ====
// IPv4 framer
// accepts an Ethernet/IP header pair, forwards the Ethernet fields,
// sends the 20 byte IPv4 header and then the payload, trimmed or
// flagged so that the byte count matches the IP total length

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module ip_tx_framer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  ip_tx_pkg::eth_hdr_t     s_eth_hdr,
    input  ip_tx_pkg::ip_hdr_t      s_ip_hdr,
    input  logic                    s_valid,
    output logic                    s_ready,
    input  ip_tx_pkg::stream_beat_t s_beat,
    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output ip_tx_pkg::eth_hdr_t     m_eth_hdr,
    output ip_tx_pkg::stream_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready_reg,
    input  logic                    out_ready_early,
    output logic                    busy,
    output logic                    error_early_term
);
    import ip_tx_pkg::*;

    framer_state_t state_reg, state_next;
    hdr_idx_t      idx_reg, idx_next;
    ip_len_t       count_reg, count_next;

    eth_hdr_t eth_hdr_reg;
    ip_hdr_t  ip_hdr_reg;
    byte_t    last_byte_reg;
    logic     store_hdr;
    logic     store_last;

    logic s_hdr_ready_reg, s_hdr_ready_next;
    logic s_ready_reg, s_ready_next;
    logic m_hdr_valid_reg, m_hdr_valid_next;
    logic busy_reg;
    logic error_reg, error_next;

    csum_t csum;
    logic  csum_advance;

    // header bytes in wire order, index 0 goes out first
    byte_t [0:`IP_HDR_BYTES-1] hdr_bytes;

    assign hdr_bytes = {`IP_VERSION, `IP_IHL, ip_hdr_reg.dscp, ip_hdr_reg.ecn,
                        ip_hdr_reg.length, ip_hdr_reg.identification,
                        ip_hdr_reg.flags, ip_hdr_reg.fragment_offset,
                        ip_hdr_reg.ttl, ip_hdr_reg.protocol, csum,
                        ip_hdr_reg.source_ip, ip_hdr_reg.dest_ip};

    ip_hdr_checksum u_checksum (
        .clk     (clk),
        .hdr     (ip_hdr_reg),
        .idx     (idx_reg),
        .advance (csum_advance),
        .csum    (csum)
    );

    always_comb begin
        state_next = state_reg;
        idx_next = idx_reg;
        count_next = count_reg;
        store_hdr = 1'b0;
        store_last = 1'b0;
        s_hdr_ready_next = 1'b0;
        s_ready_next = 1'b0;
        m_hdr_valid_next = m_hdr_valid_reg && !m_hdr_ready;
        error_next = 1'b0;
        csum_advance = 1'b0;
        out_beat = '0;
        out_valid = 1'b0;

        case (state_reg)
            IDLE: begin
                idx_next = '0;
                s_hdr_ready_next = !m_hdr_valid_next;
                if (s_hdr_ready_reg && s_hdr_valid) begin
                    store_hdr = 1'b1;
                    s_hdr_ready_next = 1'b0;
                    m_hdr_valid_next = 1'b1;
                    // byte 0 is constant, send it in the accept cycle
                    if (out_ready_reg) begin
                        out_valid = 1'b1;
                        out_beat.data = hdr_bytes[0];
                        idx_next = hdr_idx_t'(1);
                    end
                    state_next = WRITE_HEADER;
                end
            end
            WRITE_HEADER: begin
                count_next = ip_hdr_reg.length - ip_len_t'(`IP_HDR_BYTES);
                if (out_ready_reg) begin
                    out_valid = 1'b1;
                    out_beat.data = hdr_bytes[idx_reg];
                    csum_advance = 1'b1;
                    idx_next = idx_reg + 1'b1;
                    if (idx_reg == hdr_idx_t'(`IP_HDR_BYTES - 1)) begin
                        s_ready_next = out_ready_early;
                        state_next = WRITE_PAYLOAD;
                    end
                end
            end
            WRITE_PAYLOAD: begin
                s_ready_next = out_ready_early;
                out_beat = s_beat;
                if (s_ready_reg && s_valid) begin
                    count_next = count_reg - 1'b1;
                    out_valid = 1'b1;
                    if (s_beat.last) begin
                        // input ended before the IP length was reached
                        if (count_reg != ip_len_t'(1)) begin
                            out_beat.user = 1'b1;
                            error_next = 1'b1;
                        end
                        s_hdr_ready_next = !m_hdr_valid_next;
                        s_ready_next = 1'b0;
                        state_next = IDLE;
                    end else if (count_reg == ip_len_t'(1)) begin
                        // final byte waits until the extra input is drained
                        store_last = 1'b1;
                        out_valid = 1'b0;
                        state_next = WRITE_PAYLOAD_LAST;
                    end
                end
            end
            WRITE_PAYLOAD_LAST: begin
                s_ready_next = out_ready_early;
                out_beat.data = last_byte_reg;
                out_beat.last = 1'b1;
                out_beat.user = s_beat.user;
                if (s_ready_reg && s_valid && s_beat.last) begin
                    out_valid = 1'b1;
                    s_hdr_ready_next = !m_hdr_valid_next;
                    s_ready_next = 1'b0;
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
            idx_reg <= '0;
            count_reg <= '0;
            s_hdr_ready_reg <= 1'b0;
            s_ready_reg <= 1'b0;
            m_hdr_valid_reg <= 1'b0;
            busy_reg <= 1'b0;
            error_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            idx_reg <= idx_next;
            count_reg <= count_next;
            s_hdr_ready_reg <= s_hdr_ready_next;
            s_ready_reg <= s_ready_next;
            m_hdr_valid_reg <= m_hdr_valid_next;
            busy_reg <= (state_next != IDLE);
            error_reg <= error_next;
        end
    end

    // header fields and the held-back byte
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            eth_hdr_reg <= s_eth_hdr;
            ip_hdr_reg <= s_ip_hdr;
        end
        if (store_last) begin
            last_byte_reg <= s_beat.data;
        end
    end

    assign s_hdr_ready = s_hdr_ready_reg;
    assign s_ready = s_ready_reg;
    assign m_hdr_valid = m_hdr_valid_reg;
    assign m_eth_hdr = eth_hdr_reg;
    assign busy = busy_reg;
    assign error_early_term = error_reg;

endmodule

`default_nettype wire

// ==== axis_skid_buffer.sv ====
// output skid buffer
// output register plus one spare register, so the upstream ready can
// be registered without losing a beat under back-pressure

`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  ip_tx_pkg::stream_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    ready_reg,
    output logic                    ready_early,
    output ip_tx_pkg::stream_beat_t m_beat,
    output logic                    m_valid,
    input  logic                    m_ready
);
    import ip_tx_pkg::*;

    stream_beat_t out_reg;
    stream_beat_t temp_reg;
    logic         out_valid_reg, out_valid_next;
    logic         temp_valid_reg, temp_valid_next;

    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // ready next cycle unless the spare register could fill up
    assign ready_early = m_ready || (!temp_valid_reg && (!out_valid_reg || !in_valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_ready || !out_valid_reg) begin
                out_valid_next = in_valid;
                in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = in_valid;
                in_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            out_valid_next = temp_valid_reg;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            ready_reg <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_reg <= in_beat;
        end else if (temp_to_out) begin
            out_reg <= temp_reg;
        end
        if (in_to_temp) begin
            temp_reg <= in_beat;
        end
    end

    assign m_beat = out_reg;
    assign m_valid = out_valid_reg;

endmodule

`default_nettype wire

// ==== ip_eth_tx.sv ====
// IPv4 frame transmitter
// IP header fields and payload bytes in, Ethernet header and
// Ethernet payload stream out
// framer builds the IPv4 header, skid buffer registers the output

`timescale 1ns/1ps
`default_nettype none

module ip_eth_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  ip_tx_pkg::eth_hdr_t     s_eth_hdr,
    input  ip_tx_pkg::ip_hdr_t      s_ip_hdr,
    input  logic                    s_valid,
    output logic                    s_ready,
    input  ip_tx_pkg::stream_beat_t s_beat,
    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output ip_tx_pkg::eth_hdr_t     m_eth_hdr,
    output logic                    m_valid,
    input  logic                    m_ready,
    output ip_tx_pkg::stream_beat_t m_beat,
    output logic                    busy,
    output logic                    error_early_term
);
    import ip_tx_pkg::*;

    // framer to skid buffer
    stream_beat_t beat_int;
    logic         valid_int;
    logic         ready_reg_int;
    logic         ready_early_int;

    ip_tx_framer u_framer (
        .clk              (clk),
        .rst              (rst),
        .s_hdr_valid      (s_hdr_valid),
        .s_hdr_ready      (s_hdr_ready),
        .s_eth_hdr        (s_eth_hdr),
        .s_ip_hdr         (s_ip_hdr),
        .s_valid          (s_valid),
        .s_ready          (s_ready),
        .s_beat           (s_beat),
        .m_hdr_valid      (m_hdr_valid),
        .m_hdr_ready      (m_hdr_ready),
        .m_eth_hdr        (m_eth_hdr),
        .out_beat         (beat_int),
        .out_valid        (valid_int),
        .out_ready_reg    (ready_reg_int),
        .out_ready_early  (ready_early_int),
        .busy             (busy),
        .error_early_term (error_early_term)
    );

    axis_skid_buffer u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (beat_int),
        .in_valid    (valid_int),
        .ready_reg   (ready_reg_int),
        .ready_early (ready_early_int),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

`default_nettype wire

// ==== ip_eth_tx_props.sv ====
// IPv4 transmitter properties
// stream and header hold rules on the outputs, quiet outputs in reset

`timescale 1ns/1ps
`default_nettype none

module ip_eth_tx_props (
    input logic                    clk,
    input logic                    rst,
    input logic                    s_hdr_ready,
    input logic                    s_ready,
    input logic                    m_hdr_valid,
    input logic                    m_hdr_ready,
    input ip_tx_pkg::eth_hdr_t     m_eth_hdr,
    input logic                    m_valid,
    input logic                    m_ready,
    input ip_tx_pkg::stream_beat_t m_beat,
    input logic                    busy,
    input logic                    error_early_term
);
    // stalled beat stays put
    beat_hold: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
        else $error("output beat changed while stalled");

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_eth_hdr))
        else $error("output header changed while stalled");

    // registered outputs are low after a reset edge
    reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !(s_hdr_ready || s_ready || m_hdr_valid || m_valid
                         || busy || error_early_term))
        else $error("control output high during reset");

endmodule

bind ip_eth_tx ip_eth_tx_props u_props (.*);

`default_nettype wire

// ==== tb_ip_eth_tx.sv ====
// testbench for the IPv4 frame transmitter
// frames come from the tests file, payload and back-pressure from an
// xorshift generator; output beats and headers are checked in order

`timescale 1ns/1ps
`default_nettype none

`include "ip_tx_defines.svh"

module tb_ip_eth_tx;
    import ip_tx_pkg::*;

    logic clk = 1'b0;
    logic rst;
    logic s_hdr_valid, s_hdr_ready;
    eth_hdr_t s_eth_hdr, m_eth_hdr;
    ip_hdr_t s_ip_hdr;
    logic s_valid, s_ready;
    stream_beat_t s_beat, m_beat;
    logic m_hdr_valid, m_hdr_ready;
    logic m_valid, m_ready;
    logic busy, error_early_term;

    eth_hdr_t eth_a[$];
    ip_hdr_t ip_a[$];
    int cnt_a[$];
    csum_t csum_a[$];

    stream_beat_t exp_q[$];
    eth_hdr_t eth_q[$];
    logic [31:0] pay_state;
    logic [31:0] bp_state;
    int err_seen;
    int err_expected;
    int limit_cycles;
    logic loaded;

    ip_eth_tx dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // complemented ones' complement sum of the ten header words
    function automatic csum_t header_csum(input ip_hdr_t h);
        logic [159:0] w;
        logic [16:0] acc;
        acc = '0;
        w = {8'h45, h.dscp, h.ecn, h.length, h.identification, h.flags,
             h.fragment_offset, h.ttl, h.protocol, 16'h0000, h.source_ip, h.dest_ip};
        for (int i = 0; i < 10; i++) begin
            acc = {1'b0, acc[15:0]} + {1'b0, w[159-16*i -: 16]};
            acc = {1'b0, acc[15:0]} + {16'h0, acc[16]};
        end
        return ~acc[15:0];
    endfunction

    task automatic load_tests();
        int fd;
        int n;
        string line;
        logic [47:0] dmac, smac;
        logic [15:0] etype, len, ident, csum;
        logic [5:0] dscp;
        logic [1:0] ecn;
        logic [2:0] flags;
        logic [12:0] frag;
        logic [7:0] ttl, proto;
        logic [31:0] sip, dip;
        int count;
        fd = $fopen("ip_eth_tx_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file");
            $display("TEST FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 10 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        dmac, smac, etype, dscp, ecn, len, ident, flags, frag,
                        ttl, proto, sip, dip, count, csum);
            if (n != 15) begin
                $display("malformed line in the tests file");
                $display("TEST FAILED");
                $fatal(1);
            end
            eth_a.push_back({dmac, smac, etype});
            ip_a.push_back({dscp, ecn, len, ident, flags, frag, ttl, proto, sip, dip});
            cnt_a.push_back(count);
            csum_a.push_back(csum);
        end
        $fclose(fd);
    endtask

    // expected header bytes and trimmed payload for one frame
    task automatic build_expected(input int f, input byte_t pay[$]);
        ip_hdr_t h;
        logic [159:0] hb;
        int want, outn;
        stream_beat_t b;
        h = ip_a[f];
        check_value("checksum_file", csum_a[f], header_csum(h));
        hb = {8'h45, h.dscp, h.ecn, h.length, h.identification, h.flags,
              h.fragment_offset, h.ttl, h.protocol, csum_a[f], h.source_ip, h.dest_ip};
        want = int'(h.length) - `IP_HDR_BYTES;
        outn = (cnt_a[f] < want) ? cnt_a[f] : want;
        for (int i = 0; i < `IP_HDR_BYTES; i++) begin
            exp_q.push_back({hb[159-8*i -: 8], 1'b0, 1'b0});
        end
        for (int i = 0; i < outn; i++) begin
            b.data = pay[i];
            b.last = (i == outn - 1);
            b.user = (i == outn - 1) && (cnt_a[f] < want);
            exp_q.push_back(b);
        end
        if (cnt_a[f] < want) err_expected++;
        eth_q.push_back(eth_a[f]);
    endtask

    task automatic send_frame(input int f);
        byte_t pay[$];
        int sent;
        for (int i = 0; i < cnt_a[f]; i++) begin
            pay_state = xorshift32(pay_state);
            pay.push_back(pay_state[7:0]);
        end
        build_expected(f, pay);
        @(negedge clk);
        s_eth_hdr = eth_a[f];
        s_ip_hdr = ip_a[f];
        s_hdr_valid = 1'b1;
        do @(posedge clk); while (!s_hdr_ready);
        sent = 0;
        while (sent < cnt_a[f]) begin
            @(negedge clk);
            // frame in progress until the final input beat is taken
            check_value("busy", busy, 1'b1);
            s_hdr_valid = 1'b0;
            pay_state = xorshift32(pay_state);
            s_beat.data = pay[sent];
            s_beat.last = (sent == cnt_a[f] - 1);
            s_beat.user = 1'b0;
            s_valid = (pay_state[9:8] != 2'b00);
            @(posedge clk);
            if (s_valid && s_ready) sent++;
        end
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        s_valid = 1'b0;
    endtask

    // random back-pressure on both output channels
    always @(negedge clk) begin
        bp_state = xorshift32(bp_state);
        m_ready = bp_state[0] | bp_state[1];
        m_hdr_ready = bp_state[2];
    end

    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat arrived with nothing expected");
                $display("TEST FAILED");
                $fatal(1);
            end
            check_value("m_beat", m_beat, exp_q.pop_front());
        end
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            if (eth_q.size() == 0) begin
                $display("output header arrived with nothing expected");
                $display("TEST FAILED");
                $fatal(1);
            end
            check_value("m_eth_hdr", m_eth_hdr, eth_q.pop_front());
        end
        if (!rst && error_early_term) err_seen++;
    end

    // watchdog scaled by the bytes in the tests file
    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the output stream did not complete");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        int total;
        rst = 1'b1;
        s_hdr_valid = 1'b0;
        s_eth_hdr = '0;
        s_ip_hdr = '0;
        s_valid = 1'b0;
        s_beat = '0;
        m_ready = 1'b0;
        m_hdr_ready = 1'b0;
        pay_state = 32'h7f349c85;
        bp_state = xorshift32(32'h7f349c85 ^ 32'h5a5a5a5a);
        err_seen = 0;
        err_expected = 0;
        loaded = 1'b0;
        load_tests();
        total = 0;
        foreach (cnt_a[i]) total += cnt_a[i] + `IP_HDR_BYTES;
        limit_cycles = total * 16 + 500;
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (cnt_a[i]) send_frame(i);
        while (exp_q.size() != 0 || eth_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        check_value("error_early_term_pulses", err_seen, err_expected);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ip_eth_tx_tests.txt ====
# one frame per line, all fields in hex
# dest_mac src_mac eth_type dscp ecn length ident flags frag ttl proto src_ip dest_ip count csum
# count is the number of payload bytes driven, csum the expected header checksum
# exact length, 12 payload bytes
0a1b2c3d4e5f 020000000001 0800 00 0 0020 1234 2 0000 40 11 c0a80001 c0a80002 0c a745
# short, 2 of 4 bytes
ffffffffffff 020000000002 0800 2e 1 0018 0001 0 0010 80 06 0a000001 0a0000fe 02 2518
# long, 13 bytes in for 8 out
001122334455 66778899aabb 0800 00 0 001c ffff 7 1fff ff ff ffffffff 00000000 0d bae3
# exact length, single payload byte
a0a1a2a3a4a5 b0b1b2b3b4b5 0800 00 3 0015 abcd 0 0000 01 01 01020304 05060708 01 fe04
# short, input ends on its first byte
123456789abc def012345678 0800 3f 0 0028 0000 1 0123 22 33 11223344 55667788 01 6530
# long, 5 bytes in for 2 out
c0ffee000001 c0ffee000002 86dd 00 0 0016 8000 0 0000 40 01 c0000201 c6336401 05 0eb1

// ==== project.f ====
+incdir+.
ip_tx_pkg.sv
ip_hdr_checksum.sv
ip_tx_framer.sv
axis_skid_buffer.sv
ip_eth_tx.sv
ip_eth_tx_props.sv
tb_ip_eth_tx.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ip_eth_tx
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf $(BUILD_DIR)
